// File: logic/rx_pkg.sv
`default_nettype none

package rx_pkg;

	// one byte of the receive stream
	typedef struct packed {
		logic       valid;
		logic       sof;
		logic       eof;
		// only meaningful with eof
		logic       good;
		logic [7:0] data;
	} rx_beat_t;

	typedef struct packed {
		logic [1:0] red_mode;
		logic [7:0] seg_max;
	} rx_ctrl_t;

	typedef struct packed {
		logic [15:0] frames;
		logic [15:0] ok;
		logic        done;
	} seg_result_t;

	// vote buffer depth in bytes
	localparam int max_frame_len = 64;
	localparam int frame_aw = $clog2(max_frame_len);

	localparam logic [31:0] crc_poly = 32'h04C1_1DB7;
	// register value after a good frame plus its fcs
	localparam logic [31:0] crc_residue = 32'hDEBB_20E3;

	localparam logic [7:0] sfd_byte = 8'hD5;
	localparam logic [7:0] preamble_byte = 8'h55;

	// reserved code falls back to a single copy
	function automatic logic [2:0] copies_of(input logic [1:0] red_mode);
		case (red_mode)
			2'd1: return 3'd3;
			2'd2: return 3'd5;
			default: return 3'd1;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: logic/rx_preamble_strip.sv
`timescale 1ns/10ps
`default_nettype none

module rx_preamble_strip (
	input  wire              clk125MHz,
	input  wire              arst_n,
	input  wire  [7:0]       rx_data,
	input  wire              rx_valid,
	input  wire              rx_error,
	output rx_pkg::rx_beat_t beat
);
	import rx_pkg::*;

	enum logic [1:0] {st_idle, st_pre, st_pay} state;

	// one byte held back so eof can land on the last byte
	logic [7:0] hold_data;
	logic       hold_valid;
	logic       hold_sof;
	logic       err_seen;

	always_ff @(posedge clk125MHz or negedge arst_n) begin
		if (!arst_n) begin
			state      <= st_idle;
			hold_valid <= 1'b0;
			hold_sof   <= 1'b0;
			err_seen   <= 1'b0;
			beat       <= '0;
		end else begin
			beat <= '0;
			case (state)
				st_idle: begin
					if (rx_valid && rx_data == preamble_byte) begin
						state    <= st_pre;
						err_seen <= rx_error;
					end
				end
				st_pre: begin
					if (!rx_valid) begin
						state <= st_idle;
					end else begin
						err_seen <= err_seen | rx_error;
						if (rx_data == sfd_byte) begin
							state      <= st_pay;
							hold_valid <= 1'b0;
						end else if (rx_data != preamble_byte) begin
							state <= st_idle;
						end
					end
				end
				default: begin
					if (rx_valid) begin
						err_seen   <= err_seen | rx_error;
						hold_valid <= 1'b1;
						hold_sof   <= !hold_valid;
						if (hold_valid) begin
							beat.valid <= 1'b1;
							beat.sof   <= hold_sof;
							beat.data  <= hold_data;
						end
					end else begin
						state      <= st_idle;
						hold_valid <= 1'b0;
						// single byte runts are dropped
						if (hold_valid && !hold_sof) begin
							beat.valid <= 1'b1;
							beat.eof   <= 1'b1;
							beat.good  <= !err_seen;
							beat.data  <= hold_data;
						end
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (state == st_pay && rx_valid)
			hold_data <= rx_data;
	end

	a_no_sof_eof: assert property (@(posedge clk125MHz) disable iff (!arst_n)
		beat.valid |-> !(beat.sof && beat.eof));

endmodule

`default_nettype wire

// File: logic/rx_crc_check.sv
`timescale 1ns/10ps
`default_nettype none

module rx_crc_check (
	input  wire              clk125MHz,
	input  wire              arst_n,
	input  wire              rx_pkg::rx_beat_t in_beat,
	output rx_pkg::rx_beat_t out_beat,
	output logic             crc_err_pulse
);
	import rx_pkg::*;

	logic [31:0]      crc;
	logic [31:0]      crc_next;
	logic             crc_ok;
	logic [2:0]       fill;
	logic [2:0]       fill_cur;
	logic             first_pend;
	// last four bytes, index 3 is the oldest
	logic [3:0][7:0]  dl;

	// lsb first update, ethernet bit order
	function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		logic [31:0] p;
		r = c;
		p = {<<{crc_poly}};
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ p;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	always_comb begin
		crc_next = crc_byte(in_beat.sof ? 32'hFFFF_FFFF : crc, in_beat.data);
		fill_cur = in_beat.sof ? 3'd0 : fill;
	end

	assign crc_ok = (crc_next == crc_residue) && in_beat.good;

	always_ff @(posedge clk125MHz or negedge arst_n) begin
		if (!arst_n) begin
			crc           <= '0;
			fill          <= '0;
			first_pend    <= 1'b0;
			out_beat      <= '0;
			crc_err_pulse <= 1'b0;
		end else begin
			out_beat      <= '0;
			crc_err_pulse <= 1'b0;
			if (in_beat.valid) begin
				crc  <= crc_next;
				fill <= (fill_cur == 3'd4) ? 3'd4 : fill_cur + 3'd1;
				if (in_beat.sof)
					first_pend <= 1'b1;
				// the fcs itself never leaves the delay line
				if (fill_cur == 3'd4) begin
					out_beat.valid <= 1'b1;
					out_beat.sof   <= first_pend;
					out_beat.eof   <= in_beat.eof;
					out_beat.good  <= in_beat.eof && crc_ok;
					out_beat.data  <= dl[3];
					first_pend     <= 1'b0;
				end
				crc_err_pulse <= in_beat.eof && !crc_ok;
			end
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (in_beat.valid)
			dl <= {dl[2:0], in_beat.data};
	end

endmodule

`default_nettype wire

// File: logic/rx_majority_vote.sv
`timescale 1ns/10ps
`default_nettype none

module rx_majority_vote (
	input  wire              clk125MHz,
	input  wire              arst_n,
	input  wire              rx_pkg::rx_ctrl_t ctrl,
	input  wire              rx_pkg::rx_beat_t in_beat,
	output rx_pkg::rx_beat_t out_beat,
	output logic             group_err_pulse
);
	import rx_pkg::*;

	// eight 3-bit vote counters per byte position
	logic [23:0]         cnt_mem [max_frame_len];

	logic                grp_active;
	logic                grp_bad;
	logic                copy_skip;
	logic [2:0]          copies;
	logic [2:0]          copy_idx;
	logic [frame_aw:0]   pos;
	logic [frame_aw:0]   first_len;

	logic                new_grp;
	logic [2:0]          copies_cur;
	logic [2:0]          idx_cur;
	logic                first_copy;
	logic                last_copy;
	logic                use_byte;
	logic [frame_aw:0]   pos_cur;
	logic [frame_aw:0]   len_now;
	logic [frame_aw:0]   limit;
	logic                fail;
	logic [23:0]         cnt_rd;
	logic [23:0]         cnt_sum;
	logic [7:0]          voted;

	always_comb begin
		new_grp    = in_beat.valid && in_beat.sof && !grp_active;
		copies_cur = grp_active ? copies : copies_of(ctrl.red_mode);
		idx_cur    = grp_active ? copy_idx : 3'd0;
		first_copy = (idx_cur == 3'd0);
		last_copy  = (idx_cur == copies_cur - 3'd1);
		pos_cur    = in_beat.sof ? '0 : pos;
		len_now    = pos_cur + 1'b1;
		limit      = first_copy ? (frame_aw+1)'(max_frame_len) : first_len;
		use_byte   = in_beat.valid && !(grp_bad && !new_grp) && !(copy_skip && !in_beat.sof);
		// too long shows up at the limit, too short at eof
		fail       = use_byte && ((!in_beat.eof && len_now == limit) ||
			(in_beat.eof && !first_copy && len_now != first_len));
		cnt_rd     = cnt_mem[pos_cur[frame_aw-1:0]];
		for (int b = 0; b < 8; b++) begin
			cnt_sum[3*b +: 3] = (first_copy ? 3'd0 : cnt_rd[3*b +: 3]) +
				{2'b00, in_beat.data[b]};
			voted[b] = cnt_sum[3*b +: 3] > (copies_cur >> 1);
		end
	end

	// first copy overwrites, so a dropped group leaves nothing behind
	always_ff @(posedge clk125MHz) begin
		if (use_byte)
			cnt_mem[pos_cur[frame_aw-1:0]] <= last_copy ? 24'd0 : cnt_sum;
	end

	always_ff @(posedge clk125MHz or negedge arst_n) begin
		if (!arst_n) begin
			grp_active      <= 1'b0;
			grp_bad         <= 1'b0;
			copy_skip       <= 1'b0;
			copies          <= 3'd1;
			copy_idx        <= '0;
			pos             <= '0;
			first_len       <= '0;
			out_beat        <= '0;
			group_err_pulse <= 1'b0;
		end else begin
			out_beat        <= '0;
			group_err_pulse <= fail;
			if (in_beat.valid) begin
				pos       <= len_now;
				copy_skip <= ((copy_skip && !in_beat.sof) || fail) && !in_beat.eof;
				if (new_grp) begin
					grp_active <= 1'b1;
					grp_bad    <= 1'b0;
					copies     <= copies_cur;
					copy_idx   <= '0;
				end
				if (fail)
					grp_bad <= 1'b1;
				if (use_byte && last_copy) begin
					out_beat.valid <= 1'b1;
					out_beat.sof   <= (pos_cur == '0);
					out_beat.eof   <= in_beat.eof || fail;
					out_beat.good  <= !fail;
					out_beat.data  <= voted;
				end
				if (in_beat.eof) begin
					if (first_copy && use_byte)
						first_len <= len_now;
					if (last_copy) begin
						grp_active <= 1'b0;
						grp_bad    <= 1'b0;
					end else begin
						copy_idx <= idx_cur + 3'd1;
					end
				end
			end
		end
	end

	a_mode_valid: assert property (@(posedge clk125MHz) disable iff (!arst_n)
		grp_active |-> ctrl.red_mode != 2'd3);

endmodule

`default_nettype wire

// File: logic/rx_segment_check.sv
`timescale 1ns/10ps
`default_nettype none

module rx_segment_check (
	input  wire                 clk125MHz,
	input  wire                 arst_n,
	input  wire                 rx_pkg::rx_ctrl_t ctrl,
	input  wire                 clr_counts,
	input  wire                 rx_pkg::rx_beat_t in_beat,
	output rx_pkg::seg_result_t result
);
	import rx_pkg::*;

	logic [7:0] pos;
	logic [7:0] seg;
	logic       pat_ok;
	logic [7:0] expected;

	logic [7:0] pos_cur;
	logic [7:0] seg_cur;
	logic       pat_cur;
	logic       frame_ok;

	// byte 0 carries the segment number, the rest count up from it
	always_comb begin
		pos_cur  = in_beat.sof ? 8'd0 : pos;
		seg_cur  = in_beat.sof ? in_beat.data : seg;
		pat_cur  = in_beat.sof || (pat_ok && in_beat.data == seg + pos_cur);
		frame_ok = pat_cur && seg_cur == expected && seg_cur < ctrl.seg_max;
	end

	always_ff @(posedge clk125MHz or negedge arst_n) begin
		if (!arst_n) begin
			pos      <= '0;
			seg      <= '0;
			pat_ok   <= 1'b0;
			expected <= '0;
			result   <= '0;
		end else begin
			if (in_beat.valid) begin
				pos    <= pos_cur + 8'd1;
				seg    <= seg_cur;
				pat_ok <= pat_cur;
			end
			if (clr_counts) begin
				expected <= '0;
				result   <= '0;
			end else if (in_beat.valid && in_beat.eof && in_beat.good) begin
				// aborted groups end with good low and are not counted
				expected      <= seg_cur + 8'd1;
				result.frames <= result.frames + 16'd1;
				if (frame_ok)
					result.ok <= result.ok + 16'd1;
				if (seg_cur == ctrl.seg_max - 8'd1)
					result.done <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/rx_csr_axil.sv
`timescale 1ns/10ps
`default_nettype none

module rx_csr_axil (
	input  wire                 clk125MHz,
	input  wire                 arst_n,
	input  wire  [7:0]          awaddr,
	input  wire                 awvalid,
	output logic                awready,
	input  wire  [31:0]         wdata,
	input  wire  [3:0]          wstrb,
	input  wire                 wvalid,
	output logic                wready,
	output logic [1:0]          bresp,
	output logic                bvalid,
	input  wire                 bready,
	input  wire  [7:0]          araddr,
	input  wire                 arvalid,
	output logic                arready,
	output logic [31:0]         rdata,
	output logic [1:0]          rresp,
	output logic                rvalid,
	input  wire                 rready,
	input  wire                 crc_err_pulse,
	input  wire                 group_err_pulse,
	input  wire                 rx_pkg::seg_result_t result,
	output rx_pkg::rx_ctrl_t    ctrl,
	output logic                clr_counts
);
	import rx_pkg::*;

	logic        wr_go;
	logic        rd_go;
	logic        clr_hit;
	logic [15:0] crc_cnt;
	logic [15:0] grp_cnt;
	logic [31:0] rd_word;

	assign wr_go   = awvalid && awready && wvalid && wready;
	assign rd_go   = arvalid && arready;
	assign clr_hit = wr_go && awaddr == 8'h0C;
	assign bresp   = 2'b00;
	assign rresp   = 2'b00;

	always_comb begin
		case (araddr)
			8'h00:   rd_word = {16'h0, ctrl.seg_max, 6'h0, ctrl.red_mode};
			8'h04:   rd_word = {16'h0, result.frames};
			8'h08:   rd_word = {16'h0, result.ok};
			8'h0C:   rd_word = {31'h0, result.done};
			8'h10:   rd_word = {16'h0, crc_cnt};
			8'h14:   rd_word = {16'h0, grp_cnt};
			default: rd_word = 32'h0;
		endcase
	end

	always_ff @(posedge clk125MHz or negedge arst_n) begin
		if (!arst_n) begin
			awready      <= 1'b0;
			wready       <= 1'b0;
			bvalid       <= 1'b0;
			arready      <= 1'b0;
			rvalid       <= 1'b0;
			ctrl.red_mode <= 2'd0;
			ctrl.seg_max <= 8'd1;
			clr_counts   <= 1'b0;
			crc_cnt      <= '0;
			grp_cnt      <= '0;
		end else begin
			// address and data are taken together in one beat
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (wr_go)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			arready <= arvalid && !arready && !rvalid;
			if (rd_go)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;

			if (wr_go && awaddr == 8'h00) begin
				if (wstrb[0])
					ctrl.red_mode <= wdata[1:0];
				if (wstrb[1])
					ctrl.seg_max <= wdata[15:8];
			end
			clr_counts <= clr_hit;

			// error counters stick at all ones
			if (clr_hit)
				crc_cnt <= '0;
			else if (crc_err_pulse && crc_cnt != 16'hFFFF)
				crc_cnt <= crc_cnt + 16'd1;
			if (clr_hit)
				grp_cnt <= '0;
			else if (group_err_pulse && grp_cnt != 16'hFFFF)
				grp_cnt <= grp_cnt + 16'd1;
		end
	end

	always_ff @(posedge clk125MHz) begin
		if (rd_go)
			rdata <= rd_word;
	end

	a_bvalid_cause: assert property (@(posedge clk125MHz) disable iff (!arst_n)
		$rose(bvalid) |-> $past(wr_go));
	a_rvalid_cause: assert property (@(posedge clk125MHz) disable iff (!arst_n)
		$rose(rvalid) |-> $past(rd_go));

endmodule

`default_nettype wire

// File: logic/rx_top.sv
`timescale 1ns/10ps
`default_nettype none

module rx_top (
	input  wire              clk125MHz,
	input  wire              arst_n,
	input  wire  [7:0]       rx_data,
	input  wire              rx_valid,
	input  wire              rx_error,
	input  wire  [7:0]       awaddr,
	input  wire              awvalid,
	output logic             awready,
	input  wire  [31:0]      wdata,
	input  wire  [3:0]       wstrb,
	input  wire              wvalid,
	output logic             wready,
	output logic [1:0]       bresp,
	output logic             bvalid,
	input  wire              bready,
	input  wire  [7:0]       araddr,
	input  wire              arvalid,
	output logic             arready,
	output logic [31:0]      rdata,
	output logic [1:0]       rresp,
	output logic             rvalid,
	input  wire              rready,
	output rx_pkg::rx_beat_t voted
);
	import rx_pkg::*;

	rx_beat_t    strip_beat;
	rx_beat_t    crc_beat;
	rx_beat_t    vote_beat;
	logic        crc_err_pulse;
	logic        group_err_pulse;
	seg_result_t result;
	rx_ctrl_t    ctrl;
	logic        clr_counts;

	// voted stream also feeds the display path
	assign voted = vote_beat;

	rx_preamble_strip i_strip (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.beat(strip_beat)
	);

	rx_crc_check i_crc (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.in_beat(strip_beat),
		.out_beat(crc_beat),
		.crc_err_pulse(crc_err_pulse)
	);

	rx_majority_vote i_vote (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.in_beat(crc_beat),
		.out_beat(vote_beat),
		.group_err_pulse(group_err_pulse)
	);

	rx_segment_check i_seg (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.ctrl(ctrl),
		.clr_counts(clr_counts),
		.in_beat(vote_beat),
		.result(result)
	);

	rx_csr_axil i_csr (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.crc_err_pulse(crc_err_pulse),
		.group_err_pulse(group_err_pulse),
		.result(result),
		.ctrl(ctrl),
		.clr_counts(clr_counts)
	);

endmodule

`default_nettype wire

// File: dv/rx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rx_tb;
	import rx_pkg::*;

	localparam int n_rows = 18;
	localparam int idle_gap = 12;
	localparam logic [1:0] res_ok = 2'd0;
	localparam logic [1:0] res_nok = 2'd1;
	localparam logic [1:0] res_drop = 2'd2;

	// one table row is one group of redundant copies
	typedef struct packed {
		logic       first;
		logic [1:0] red_mode;
		logic [7:0] seg_max;
		logic [7:0] seg;
		logic [7:0] len;
		logic [4:0] copy_mask;
		logic [7:0] byte_idx;
		logic [7:0] bit_mask;
		logic [7:0] len_ovr;
		logic [1:0] outcome;
	} frame_row_t;

	logic        clk125MHz;
	logic        arst_n;
	logic [7:0]  rx_data;
	logic        rx_valid;
	logic        rx_error;
	logic [7:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [7:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	rx_beat_t    voted;

	frame_row_t  rows [n_rows];
	logic        table_loaded = 1'b0;
	logic [31:0] rng_state = 32'h9dd6_697b;
	logic [7:0]  copy_pl [5][max_frame_len];
	rx_beat_t    cap_q [$];
	int          eof_count = 0;
	int          n_checks = 0;
	int          n_mismatch = 0;
	int          n_fail = 0;

	// expected register state
	rx_ctrl_t    ctrl_exp;
	seg_result_t res_exp;
	logic [15:0] crc_exp;
	logic [15:0] grp_exp;

	rx_top uut (
		.clk125MHz(clk125MHz),
		.arst_n(arst_n),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_error(rx_error),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.voted(voted)
	);

	initial begin
		clk125MHz = 1'b0;
		forever #4 clk125MHz = ~clk125MHz;
	end

	// voted port is stable at the falling edge
	always @(negedge clk125MHz) begin
		if (arst_n && voted.valid) begin
			cap_q.push_back(voted);
			if (voted.eof)
				eof_count = eof_count + 1;
		end
	end

	function automatic int copy_count(input logic [1:0] mode);
		case (mode)
			2'd1: return 3;
			2'd2: return 5;
			default: return 1;
		endcase
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// reflected crc-32, register not inverted
	function automatic logic [31:0] crc32_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		for (int i = 0; i < 8; i++)
			r = (r >> 1) ^ (32'hEDB8_8320 & {32{r[0]}});
		return r;
	endfunction

	function automatic rx_ctrl_t ctrl_after_write(input rx_ctrl_t c, input logic [31:0] d,
		input logic [3:0] s);
		rx_ctrl_t n;
		n = c;
		if (s[0])
			n.red_mode = d[1:0];
		if (s[1])
			n.seg_max = d[15:8];
		return n;
	endfunction

	function automatic logic [31:0] ctrl_word(input rx_ctrl_t c);
		return {16'h0, c.seg_max, 6'h0, c.red_mode};
	endfunction

	function automatic frame_row_t make_row(input logic first, input logic [1:0] mode,
		input logic [7:0] seg_max, input logic [7:0] seg, input logic [7:0] len,
		input logic [4:0] cmask, input logic [7:0] idx, input logic [7:0] mask,
		input logic [7:0] len_ovr, input logic [1:0] outcome);
		frame_row_t r;
		r = {first, mode, seg_max, seg, len, cmask, idx, mask, len_ovr, outcome};
		return r;
	endfunction

	// first, mode, seg_max, seg, len, copy mask, byte, bit mask (0 random), copy 1 len, result
	task automatic load_table();
		rows[0]  = make_row(1, 0, 4, 0, 12, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[1]  = make_row(0, 0, 4, 1, 5, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[2]  = make_row(0, 0, 4, 2, 64, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[3]  = make_row(0, 0, 4, 3, 20, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[4]  = make_row(1, 1, 3, 0, 16, 5'b00010, 3, 8'h00, 0, res_ok);
		rows[5]  = make_row(0, 1, 3, 1, 24, 5'b00001, 23, 8'h81, 0, res_ok);
		rows[6]  = make_row(0, 1, 3, 2, 9, 5'b00100, 0, 8'h00, 0, res_ok);
		rows[7]  = make_row(1, 2, 3, 0, 32, 5'b01001, 7, 8'h00, 0, res_ok);
		rows[8]  = make_row(0, 2, 3, 1, 18, 5'b10010, 17, 8'h00, 0, res_ok);
		rows[9]  = make_row(0, 2, 3, 2, 40, 5'b10100, 0, 8'hFF, 0, res_ok);
		rows[10] = make_row(1, 1, 4, 0, 10, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[11] = make_row(0, 1, 4, 1, 14, 5'b00000, 0, 8'h00, 11, res_drop);
		rows[12] = make_row(0, 1, 4, 1, 14, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[13] = make_row(0, 1, 4, 2, 15, 5'b00111, 6, 8'h10, 0, res_nok);
		rows[14] = make_row(0, 1, 4, 3, 8, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[15] = make_row(1, 0, 4, 0, 11, 5'b00000, 0, 8'h00, 0, res_ok);
		rows[16] = make_row(0, 0, 4, 2, 11, 5'b00000, 0, 8'h00, 0, res_nok);
		rows[17] = make_row(0, 0, 4, 3, 11, 5'b00000, 0, 8'h00, 0, res_ok);
	endtask

	task automatic report_failure(input string what);
		n_fail++;
		$display("Error: %s", what);
	endtask

	task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_mismatch++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	// good only counts on the last beat
	task automatic check_beat(input string name, input rx_beat_t got, input rx_beat_t exp);
		logic bad;
		n_checks++;
		bad = got.valid !== exp.valid || got.sof !== exp.sof || got.eof !== exp.eof ||
			got.data !== exp.data || (exp.eof && got.good !== exp.good);
		if (bad) begin
			n_mismatch++;
			$display("Mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_result(input seg_result_t got, input seg_result_t exp);
		n_checks++;
		if (got.frames !== exp.frames) begin
			n_mismatch++;
			$display("Mismatch result.frames: got %h expected %h", got.frames, exp.frames);
		end
		if (got.ok !== exp.ok) begin
			n_mismatch++;
			$display("Mismatch result.ok: got %h expected %h", got.ok, exp.ok);
		end
		if (got.done !== exp.done) begin
			n_mismatch++;
			$display("Mismatch result.done: got %h expected %h", got.done, exp.done);
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		@(negedge clk125MHz);
		awaddr  = addr;
		wdata   = data;
		wstrb   = strb;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		while (!awready && n < 50) begin
			@(negedge clk125MHz);
			n++;
		end
		if (!awready)
			report_failure($sformatf("write to %h was never accepted", addr));
		// transfer takes place on the rising edge in between
		@(negedge clk125MHz);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid && n < 50) begin
			@(negedge clk125MHz);
			n++;
		end
		if (!bvalid)
			report_failure($sformatf("no write response for %h", addr));
		else
			check_reg("bresp", {30'h0, bresp}, 32'h0);
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		@(negedge clk125MHz);
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready && n < 50) begin
			@(negedge clk125MHz);
			n++;
		end
		if (!arready)
			report_failure($sformatf("read of %h was never accepted", addr));
		@(negedge clk125MHz);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid && n < 50) begin
			@(negedge clk125MHz);
			n++;
		end
		data = rdata;
		if (!rvalid)
			report_failure($sformatf("no read response for %h", addr));
		else
			check_reg("rresp", {30'h0, rresp}, 32'h0);
	endtask

	task automatic write_ctrl(input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] w;
		axi_write(8'h00, data, strb);
		ctrl_exp = ctrl_after_write(ctrl_exp, data, strb);
		axi_read(8'h00, w);
		check_reg("ctrl", w, ctrl_word(ctrl_exp));
	endtask

	task automatic check_counters();
		logic [31:0] w;
		seg_result_t got;
		axi_read(8'h04, w);
		got.frames = w[15:0];
		axi_read(8'h08, w);
		got.ok = w[15:0];
		axi_read(8'h0C, w);
		got.done = w[0];
		check_result(got, res_exp);
		axi_read(8'h10, w);
		check_reg("crc_err_count", w, {16'h0, crc_exp});
		axi_read(8'h14, w);
		check_reg("group_err_count", w, {16'h0, grp_exp});
	endtask

	task automatic drive_byte(input logic [7:0] b);
		@(negedge clk125MHz);
		rx_valid = 1'b1;
		rx_data  = b;
		rx_error = 1'b0;
	endtask

	task automatic drive_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk125MHz);
			rx_valid = 1'b0;
			rx_data  = 8'h00;
		end
	endtask

	// fcs covers the clean payload, noise goes in afterwards
	task automatic send_copy(input frame_row_t r, input int c);
		int len;
		logic [31:0] crc;
		logic [7:0] pl;
		logic [7:0] m;
		len = (c == 1 && r.len_ovr != 8'd0) ? int'(r.len_ovr) : int'(r.len);
		crc = 32'hFFFF_FFFF;
		m = r.bit_mask;
		if (r.copy_mask[c]) begin
			if (m == 8'h00) begin
				rng_state = xorshift32(rng_state);
				m = (rng_state[7:0] == 8'h00) ? 8'h01 : rng_state[7:0];
			end
			crc_exp = crc_exp + 16'd1;
		end
		for (int k = 0; k < len; k++) begin
			pl = r.seg + 8'(k);
			crc = crc32_step(crc, pl);
			copy_pl[c][k] = (r.copy_mask[c] && k == int'(r.byte_idx)) ? pl ^ m : pl;
		end
		crc = ~crc;
		repeat (7) drive_byte(8'h55);
		drive_byte(8'hD5);
		for (int k = 0; k < len; k++)
			drive_byte(copy_pl[c][k]);
		for (int k = 0; k < 4; k++)
			drive_byte(crc[8*k +: 8]);
		drive_idle(idle_gap);
	endtask

	task automatic run_row(input int idx);
		frame_row_t r;
		int n;
		int base;
		int wait_n;
		int votes;
		logic [7:0] vb;
		rx_beat_t exp_beat;
		r = rows[idx];
		if (r.first) begin
			write_ctrl({16'h0, r.seg_max, 6'h0, r.red_mode}, 4'b0011);
			axi_write(8'h0C, 32'h0, 4'hF);
			res_exp = '0;
			crc_exp = '0;
			grp_exp = '0;
		end
		n = copy_count(r.red_mode);
		base = eof_count;
		cap_q.delete();
		for (int c = 0; c < n; c++)
			send_copy(r, c);
		if (r.outcome == res_drop) begin
			grp_exp = grp_exp + 16'd1;
			if (cap_q.size() != 0)
				report_failure($sformatf("row %0d gave a voted frame for a bad group", idx));
		end else begin
			wait_n = 0;
			while (eof_count < base + 1 && wait_n < 100) begin
				@(negedge clk125MHz);
				wait_n++;
			end
			if (eof_count < base + 1) begin
				report_failure($sformatf("row %0d never ended a voted frame", idx));
			end else if (cap_q.size() != int'(r.len)) begin
				report_failure($sformatf("row %0d voted frame has %0d bytes, not %0d",
					idx, cap_q.size(), r.len));
			end else begin
				for (int k = 0; k < int'(r.len); k++) begin
					// bitwise majority over all copies
					for (int b = 0; b < 8; b++) begin
						votes = 0;
						for (int c = 0; c < n; c++)
							if (copy_pl[c][k][b])
								votes++;
						vb[b] = (votes * 2 > n);
					end
					exp_beat.valid = 1'b1;
					exp_beat.sof   = (k == 0);
					exp_beat.eof   = (k == int'(r.len) - 1);
					exp_beat.good  = 1'b1;
					exp_beat.data  = vb;
					check_beat($sformatf("voted row %0d byte %0d", idx, k), cap_q[k], exp_beat);
				end
			end
			res_exp.frames = res_exp.frames + 16'd1;
			if (r.outcome == res_ok)
				res_exp.ok = res_exp.ok + 16'd1;
			if (r.seg == r.seg_max - 8'd1)
				res_exp.done = 1'b1;
		end
		check_counters();
	endtask

	initial begin
		int limit;
		wait (table_loaded);
		limit = 10000;
		for (int i = 0; i < n_rows; i++)
			limit += int'(rows[i].len) * copy_count(rows[i].red_mode) * 2;
		repeat (limit) @(posedge clk125MHz);
		$display("Error: watchdog expired after %0d cycles", limit);
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		logic [31:0] w;
		arst_n   = 1'b0;
		rx_data  = 8'h00;
		rx_valid = 1'b0;
		rx_error = 1'b0;
		awaddr   = 8'h00;
		awvalid  = 1'b0;
		wdata    = 32'h0;
		wstrb    = 4'h0;
		wvalid   = 1'b0;
		bready   = 1'b1;
		araddr   = 8'h00;
		arvalid  = 1'b0;
		rready   = 1'b1;
		load_table();
		table_loaded = 1'b1;
		repeat (10) @(negedge clk125MHz);
		arst_n = 1'b1;
		repeat (2) @(negedge clk125MHz);

		// values after reset
		ctrl_exp.red_mode = 2'd0;
		ctrl_exp.seg_max  = 8'd1;
		res_exp = '0;
		crc_exp = '0;
		grp_exp = '0;
		axi_read(8'h00, w);
		check_reg("ctrl", w, ctrl_word(ctrl_exp));
		check_counters();

		for (int i = 0; i < n_rows; i++)
			run_row(i);

		// byte strobes on ctrl
		write_ctrl(32'h0000_0A02, 4'b0001);
		write_ctrl(32'h0000_0701, 4'b0010);
		write_ctrl(32'h1234_5601, 4'b1111);

		// clear works without strobes and leaves ctrl alone
		axi_write(8'h0C, 32'h0, 4'h0);
		res_exp = '0;
		crc_exp = '0;
		grp_exp = '0;
		check_counters();
		axi_read(8'h00, w);
		check_reg("ctrl", w, ctrl_word(ctrl_exp));

		$display("checks %0d, mismatches %0d, other failures %0d",
			n_checks, n_mismatch, n_fail);
		if (n_mismatch == 0 && n_fail == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: project.f
logic/rx_pkg.sv
logic/rx_preamble_strip.sv
logic/rx_crc_check.sv
logic/rx_majority_vote.sv
logic/rx_segment_check.sv
logic/rx_csr_axil.sv
logic/rx_top.sv
dv/rx_tb.sv

// File: run.sh
#!/bin/sh
# builds the receive path testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rx_tb -Mdir obj_dir -f project.f

out=$(./obj_dir/Vrx_tb)
printf '%s\n' "$out"

# the exit status of this search is the exit status of the script
printf '%s\n' "$out" | grep -qx '>>> PASS'
